/* Bender.yml */
package:
  name: image_statistics

sources:
  - files:
      - common/pixel_pkg.sv
      - common/stats_pkg.sv
      - histogram/histogram_channel.sv
      - histogram/histogram.sv
      - hdl/exposure_metering.sv
      - hdl/stats_readout.sv
      - hdl/image_statistics.sv

  - target: test
    files:
      - tb/stats_checker.sv
      - tb/image_statistics_tb.sv

/* common/pixel_pkg.sv */
// Pixel stream types shared by every block that receives the demosaiced RGB stream.
`default_nettype none

package pixel_pkg;

    // ======================================================================
    // Channel samples
    // ======================================================================

    typedef logic [9:0] raw_channel_t;  // One sensor channel sample as delivered.
    typedef logic [7:0] channel_t;      // Channel value with the two low bits dropped.

    // ======================================================================
    // Channel order
    // ======================================================================

    // Fixes the order of the per-channel regions in the readout map.
    typedef enum logic [1:0] {
        CHANNEL_RED   = 2'd0,
        CHANNEL_GREEN = 2'd1,
        CHANNEL_BLUE  = 2'd2
    } channel_e;

endpackage

`default_nettype wire

/* common/stats_pkg.sv */
// Result word types and the host readout address map for the frame statistics.
`default_nettype none

package stats_pkg;

    // ======================================================================
    // Readout types
    // ======================================================================

    typedef logic [15:0] stat_word_t;    // Data word returned by the readout port.
    typedef logic [7:0]  read_address_t; // Host read address.

    // ======================================================================
    // Address map
    // ======================================================================

    // Histogram bins start at zero, channel by channel, NUM_BINS each.
    // With at most 16 bins the histogram region ends below MAX_BASE.

    localparam read_address_t MAX_BASE     = 8'd48; // Red, green, blue maxima follow.
    localparam read_address_t CLIP_ADDRESS = 8'd51; // Clipped pixel count.

endpackage

`default_nettype wire

/* filelist.f */
common/pixel_pkg.sv
common/stats_pkg.sv
histogram/histogram_channel.sv
histogram/histogram.sv
hdl/exposure_metering.sv
hdl/stats_readout.sv
hdl/image_statistics.sv
tb/stats_checker.sv
tb/image_statistics_tb.sv

/* hdl/exposure_metering.sv */
// Per-frame channel maxima and clipped pixel count used by the exposure control loop.
`timescale 1ns/1ps
`default_nettype none

module exposure_metering #(
    parameter pixel_pkg::channel_t CLIP_LEVEL = 8'd255
)(
    input  logic                    clock_in,
    input  logic                    arst_n,
    input  pixel_pkg::raw_channel_t red_in,
    input  pixel_pkg::raw_channel_t green_in,
    input  pixel_pkg::raw_channel_t blue_in,
    input  logic                    line_valid,
    input  logic                    frame_valid,
    output pixel_pkg::channel_t     red_max,
    output pixel_pkg::channel_t     green_max,
    output pixel_pkg::channel_t     blue_max,
    output stats_pkg::stat_word_t   clip_count
);

    pixel_pkg::channel_t   red_value;
    pixel_pkg::channel_t   green_value;
    pixel_pkg::channel_t   blue_value;
    pixel_pkg::channel_t   red_running;
    pixel_pkg::channel_t   green_running;
    pixel_pkg::channel_t   blue_running;
    stats_pkg::stat_word_t clip_running;

    logic previous_frame_valid;
    logic pixel_valid;
    logic frame_end;
    logic clipped;

    assign red_value   = red_in[9:2];
    assign green_value = green_in[9:2];
    assign blue_value  = blue_in[9:2];

    assign pixel_valid = frame_valid && line_valid;
    assign frame_end   = previous_frame_valid && !frame_valid;

    // One hot channel is enough to mark the whole pixel as clipped.
    assign clipped = (red_value >= CLIP_LEVEL) || (green_value >= CLIP_LEVEL)
                  || (blue_value >= CLIP_LEVEL);

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            previous_frame_valid <= 1'b0;
            red_running          <= '0;
            green_running        <= '0;
            blue_running         <= '0;
            clip_running         <= '0;
            red_max              <= '0;
            green_max            <= '0;
            blue_max             <= '0;
            clip_count           <= '0;
        end else begin
            previous_frame_valid <= frame_valid;
            if (frame_end) begin
                red_max       <= red_running;   // Same cycle as the histogram latch.
                green_max     <= green_running;
                blue_max      <= blue_running;
                clip_count    <= clip_running;
                red_running   <= '0;
                green_running <= '0;
                blue_running  <= '0;
                clip_running  <= '0;
            end else if (pixel_valid) begin
                if (red_value > red_running) red_running <= red_value;
                if (green_value > green_running) green_running <= green_value;
                if (blue_value > blue_running) blue_running <= blue_value;
                if (clipped && clip_running != '1) begin
                    clip_running <= clip_running + 1'b1;    // Holds at 65535.
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/image_statistics.sv */
// Top level of the frame statistics block, joining the pixel stream to the host readout.
`timescale 1ns/1ps
`default_nettype none

module image_statistics #(
    parameter int                  NUM_BINS    = 8,
    parameter int                  COUNT_WIDTH = 16,
    parameter pixel_pkg::channel_t CLIP_LEVEL  = 8'd255
)(
    input  logic                     clock_in,
    input  logic                     arst_n,
    input  pixel_pkg::raw_channel_t  red_in,
    input  pixel_pkg::raw_channel_t  green_in,
    input  pixel_pkg::raw_channel_t  blue_in,
    input  logic                     line_valid,
    input  logic                     frame_valid,
    input  stats_pkg::read_address_t read_address,
    output stats_pkg::stat_word_t    read_data,
    output logic                     stats_ready
);

    logic [COUNT_WIDTH-1:0] red_bins [NUM_BINS];
    logic [COUNT_WIDTH-1:0] green_bins [NUM_BINS];
    logic [COUNT_WIDTH-1:0] blue_bins [NUM_BINS];
    pixel_pkg::channel_t    red_max;
    pixel_pkg::channel_t    green_max;
    pixel_pkg::channel_t    blue_max;
    stats_pkg::stat_word_t  clip_count;

    // Both statistic blocks latch on the same cycle, so one ready level covers them.
    histogram #(.NUM_BINS(NUM_BINS), .COUNT_WIDTH(COUNT_WIDTH)) histogram_block (
        .clock_in, .arst_n, .red_in, .green_in, .blue_in, .line_valid, .frame_valid,
        .red_bins, .green_bins, .blue_bins, .histogram_ready(stats_ready)
    );

    exposure_metering #(.CLIP_LEVEL(CLIP_LEVEL)) exposure_block (
        .clock_in, .arst_n, .red_in, .green_in, .blue_in, .line_valid, .frame_valid,
        .red_max, .green_max, .blue_max, .clip_count
    );

    stats_readout #(.NUM_BINS(NUM_BINS), .COUNT_WIDTH(COUNT_WIDTH)) readout_block (
        .clock_in, .arst_n, .read_address,
        .red_bins, .green_bins, .blue_bins,
        .red_max, .green_max, .blue_max, .clip_count,
        .read_data
    );

endmodule

`default_nettype wire

/* hdl/stats_readout.sv */
// Registered read mux that maps every latched frame statistic onto the host address space.
`timescale 1ns/1ps
`default_nettype none

module stats_readout #(
    parameter int NUM_BINS    = 8,
    parameter int COUNT_WIDTH = 16
)(
    input  logic                     clock_in,
    input  logic                     arst_n,
    input  stats_pkg::read_address_t read_address,
    input  logic [COUNT_WIDTH-1:0]   red_bins [NUM_BINS],
    input  logic [COUNT_WIDTH-1:0]   green_bins [NUM_BINS],
    input  logic [COUNT_WIDTH-1:0]   blue_bins [NUM_BINS],
    input  pixel_pkg::channel_t      red_max,
    input  pixel_pkg::channel_t      green_max,
    input  pixel_pkg::channel_t      blue_max,
    input  stats_pkg::stat_word_t    clip_count,
    output stats_pkg::stat_word_t    read_data
);

    // Wide counters report their top 16 bits, narrow ones are zero-extended.
    localparam int COUNT_SHIFT = (COUNT_WIDTH > 16) ? COUNT_WIDTH - 16 : 0;

    stats_pkg::stat_word_t selected;

    function automatic stats_pkg::stat_word_t count_word(input logic [COUNT_WIDTH-1:0] count);
        return stats_pkg::stat_word_t'(count >> COUNT_SHIFT);
    endfunction

    function automatic stats_pkg::read_address_t bin_address(input pixel_pkg::channel_e channel,
                                                            input int bin);
        return stats_pkg::read_address_t'(int'(channel) * NUM_BINS + bin);
    endfunction

    function automatic stats_pkg::read_address_t max_address(input pixel_pkg::channel_e channel);
        return stats_pkg::MAX_BASE + stats_pkg::read_address_t'(channel);
    endfunction

    // ======================================================================
    // Address decode
    // ======================================================================

    always_comb begin
        selected = '0;  // Unmapped addresses read zero.
        for (int b = 0; b < NUM_BINS; b++) begin
            if (read_address == bin_address(pixel_pkg::CHANNEL_RED, b)) begin
                selected = count_word(red_bins[b]);
            end
            if (read_address == bin_address(pixel_pkg::CHANNEL_GREEN, b)) begin
                selected = count_word(green_bins[b]);
            end
            if (read_address == bin_address(pixel_pkg::CHANNEL_BLUE, b)) begin
                selected = count_word(blue_bins[b]);
            end
        end
        if (read_address == max_address(pixel_pkg::CHANNEL_RED)) selected = {8'd0, red_max};
        if (read_address == max_address(pixel_pkg::CHANNEL_GREEN)) selected = {8'd0, green_max};
        if (read_address == max_address(pixel_pkg::CHANNEL_BLUE)) selected = {8'd0, blue_max};
        if (read_address == stats_pkg::CLIP_ADDRESS) selected = clip_count;
    end

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            read_data <= '0;
        end else begin
            read_data <= selected;  // Data follows the address by one cycle.
        end
    end

endmodule

`default_nettype wire

/* histogram/histogram.sv */
// Per-frame RGB histogram built from three identical channel counters sharing frame timing.
`timescale 1ns/1ps
`default_nettype none

module histogram #(
    parameter int NUM_BINS    = 8,
    parameter int COUNT_WIDTH = 16
)(
    input  logic                    clock_in,
    input  logic                    arst_n,
    input  pixel_pkg::raw_channel_t red_in,
    input  pixel_pkg::raw_channel_t green_in,
    input  pixel_pkg::raw_channel_t blue_in,
    input  logic                    line_valid,
    input  logic                    frame_valid,
    output logic [COUNT_WIDTH-1:0]  red_bins [NUM_BINS],
    output logic [COUNT_WIDTH-1:0]  green_bins [NUM_BINS],
    output logic [COUNT_WIDTH-1:0]  blue_bins [NUM_BINS],
    output logic                    histogram_ready
);

    logic previous_frame_valid;
    logic pixel_valid;
    logic frame_end;

    assign pixel_valid = frame_valid && line_valid;
    assign frame_end   = previous_frame_valid && !frame_valid;   // Falling edge of the frame.

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            previous_frame_valid <= 1'b0;
            histogram_ready      <= 1'b0;
        end else begin
            previous_frame_valid <= frame_valid;
            if (frame_end) begin
                histogram_ready <= 1'b1;    // Latches hold the finished frame next cycle.
            end else if (frame_valid) begin
                histogram_ready <= 1'b0;
            end
        end
    end

    // ======================================================================
    // Channel counters
    // ======================================================================

    histogram_channel #(.NUM_BINS(NUM_BINS), .COUNT_WIDTH(COUNT_WIDTH)) red_channel (
        .clock_in, .arst_n, .pixel(red_in[9:2]), .pixel_valid, .frame_end,
        .bin_counts(red_bins)
    );

    histogram_channel #(.NUM_BINS(NUM_BINS), .COUNT_WIDTH(COUNT_WIDTH)) green_channel (
        .clock_in, .arst_n, .pixel(green_in[9:2]), .pixel_valid, .frame_end,
        .bin_counts(green_bins)
    );

    histogram_channel #(.NUM_BINS(NUM_BINS), .COUNT_WIDTH(COUNT_WIDTH)) blue_channel (
        .clock_in, .arst_n, .pixel(blue_in[9:2]), .pixel_valid, .frame_end,
        .bin_counts(blue_bins)
    );

    // Once a frame is under way the host must not see stale results as ready.
    ready_low_in_frame: assert property (
        @(posedge clock_in) disable iff (!arst_n)
        (frame_valid && previous_frame_valid) |-> !histogram_ready
    );

endmodule

`default_nettype wire

/* histogram/histogram_channel.sv */
// Saturating bin counters for one colour channel, latched and cleared at each frame end.
`timescale 1ns/1ps
`default_nettype none

module histogram_channel #(
    parameter int NUM_BINS    = 8,  // Power of two, 2 to 16.
    parameter int COUNT_WIDTH = 16
)(
    input  logic                    clock_in,
    input  logic                    arst_n,
    input  pixel_pkg::channel_t     pixel,
    input  logic                    pixel_valid,
    input  logic                    frame_end,
    output logic [COUNT_WIDTH-1:0]  bin_counts [NUM_BINS]
);

    localparam int INDEX_WIDTH = $clog2(NUM_BINS);

    logic [COUNT_WIDTH-1:0] counters [NUM_BINS];    // Running counts for the current frame.

    logic [INDEX_WIDTH-1:0] bin_index;
    logic                   stage_valid;            // A pixel waits to be written back.
    logic [INDEX_WIDTH-1:0] stage_index;
    logic [COUNT_WIDTH-1:0] stage_count;
    logic [COUNT_WIDTH-1:0] next_count;
    logic                   forward;

    // ======================================================================
    // Bin select and increment
    // ======================================================================

    assign bin_index  = pixel[7 -: INDEX_WIDTH];    // Equal-width bins over the 8-bit value.
    assign next_count = (stage_count == '1) ? stage_count : stage_count + 1'b1;

    // The bin being written this cycle is newer than the counter array.
    assign forward = stage_valid && (stage_index == bin_index);

    always_ff @(posedge clock_in) begin
        if (pixel_valid) begin
            stage_index <= bin_index;
            stage_count <= forward ? next_count : counters[bin_index];
        end
    end

    // ======================================================================
    // Write back, frame latch and clear
    // ======================================================================

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= 1'b0;
            for (int i = 0; i < NUM_BINS; i++) begin
                counters[i]   <= '0;
                bin_counts[i] <= '0;
            end
        end else if (frame_end) begin
            stage_valid <= 1'b0;
            for (int i = 0; i < NUM_BINS; i++) begin
                // The last pixel of the frame may still be in flight.
                bin_counts[i] <= (stage_valid && stage_index == i) ? next_count : counters[i];
                counters[i]   <= '0;
            end
        end else begin
            stage_valid <= pixel_valid;
            if (stage_valid) begin
                counters[stage_index] <= next_count;
            end
        end
    end

    // A staged pixel carries the newest count of its bin, read or forwarded.
    stage_count_current: assert property (
        @(posedge clock_in) disable iff (!arst_n)
        stage_valid |-> (stage_count == counters[stage_index])
    );

endmodule

`default_nettype wire

/* tb/image_statistics_tb.sv */
// Testbench for the frame statistics block; replays the stim file frames and sweeps the readout.
`timescale 1ns/1ps
`default_nettype none

module image_statistics_tb;

    localparam int RESET_CYCLES  = 5;
    localparam int FRAME_MARGIN  = 200;     // Drain and readout cycles allowed per frame.
    localparam int READY_TIMEOUT = 16;
    localparam     STIM_PATH     = "tb/image_stim.txt";

    logic                     clock_in;
    logic                     arst_n;
    pixel_pkg::raw_channel_t  red_in;
    pixel_pkg::raw_channel_t  green_in;
    pixel_pkg::raw_channel_t  blue_in;
    logic                     line_valid;
    logic                     frame_valid;
    stats_pkg::read_address_t read_address;
    stats_pkg::stat_word_t    read_data;
    logic                     stats_ready;
    logic                     check_valid;
    logic [8*32-1:0]          check_name;
    stats_pkg::stat_word_t    check_expected;
    int                       check_count;
    int                       error_count;
    int                       file_errors;
    int                       cycle_limit;
    int                       frame_number;

    image_statistics #(
        .NUM_BINS(8), .COUNT_WIDTH(10), .CLIP_LEVEL(8'd250)
    ) uut (
        .clock_in, .arst_n, .red_in, .green_in, .blue_in, .line_valid, .frame_valid,
        .read_address, .read_data, .stats_ready
    );

    stats_checker readout_checker (
        .clock_in, .arst_n, .frame_valid, .stats_ready, .read_data,
        .check_valid, .check_name, .check_expected, .check_count, .error_count
    );

    initial begin
        clock_in = 1'b0;
        forever #5 clock_in = ~clock_in;
    end

    // ======================================================================
    // Stim file handling
    // ======================================================================

    // Sums pixel and blanking cycles so the watchdog can size itself.
    task automatic measure_stim(output int cycles, output int frames);
        int               fd;
        int               fields;
        int               count;
        int               red;
        int               green;
        int               blue;
        int               blank;
        logic [8*128-1:0] text_line;
        logic [8*16-1:0]  word;
        cycles = 0;
        frames = 0;
        fd = $fopen(STIM_PATH, "r");
        if (fd != 0) begin
            while ($fgets(text_line, fd) != 0) begin
                word = '0;
                fields = $sscanf(text_line, "%s %d %d %d %d %d",
                                 word, count, red, green, blue, blank);
                if (word == "frame") begin
                    frames++;
                end else if (word == "run" && fields == 6) begin
                    cycles += count + blank;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_run(input int count, input int red, input int green, input int blue,
                             input int blank);
        for (int i = 0; i < count; i++) begin
            @(posedge clock_in);
            line_valid <= 1'b1;
            red_in     <= pixel_pkg::raw_channel_t'(red);
            green_in   <= pixel_pkg::raw_channel_t'(green);
            blue_in    <= pixel_pkg::raw_channel_t'(blue);
        end
        for (int i = 0; i < blank; i++) begin
            @(posedge clock_in);
            line_valid <= 1'b0;     // Horizontal blanking inside the frame.
        end
    endtask

    // Drops frame_valid right after the last pixel and waits for the latched results.
    task automatic end_frame();
        int waited;
        waited = 0;
        @(posedge clock_in);
        frame_valid <= 1'b0;
        line_valid  <= 1'b0;
        @(posedge clock_in);
        while (!stats_ready && waited < READY_TIMEOUT) begin
            @(posedge clock_in);
            waited++;
        end
    endtask

    task automatic check_readout(input int address, input int value, input logic [8*24-1:0] label);
        logic [8*32-1:0] name;
        $sformat(name, "frame%0d_%0s", frame_number, label);
        @(posedge clock_in);
        read_address <= stats_pkg::read_address_t'(address);
        @(posedge clock_in);
        check_valid    <= 1'b1;     // read_data now holds the word for this address.
        check_expected <= stats_pkg::stat_word_t'(value);
        check_name     <= name;
        @(posedge clock_in);
        check_valid <= 1'b0;
    endtask

    task automatic play_stim();
        int               fd;
        int               fields;
        int               count;
        int               red;
        int               green;
        int               blue;
        int               blank;
        logic             in_frame;
        logic [8*128-1:0] text_line;
        logic [8*16-1:0]  word;
        logic [8*24-1:0]  label;
        in_frame = 1'b0;
        fd = $fopen(STIM_PATH, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %0s.", STIM_PATH);
            file_errors++;
        end else begin
            while ($fgets(text_line, fd) != 0) begin
                word  = '0;
                label = '0;
                fields = $sscanf(text_line, "%s", word);
                if (word == "frame") begin
                    frame_number++;
                    in_frame = 1'b1;
                    @(posedge clock_in);
                    frame_valid <= 1'b1;
                    line_valid  <= 1'b0;
                end else if (word == "run") begin
                    fields = $sscanf(text_line, "%s %d %d %d %d %d",
                                     word, count, red, green, blue, blank);
                    if (fields == 6) begin
                        drive_run(count, red, green, blue, blank);
                    end else begin
                        $display("A run line has %0d fields instead of 6.", fields);
                        file_errors++;
                    end
                end else if (word == "expect") begin
                    fields = $sscanf(text_line, "%s %d %d %s", word, count, red, label);
                    if (in_frame) begin
                        end_frame();
                        in_frame = 1'b0;
                    end
                    if (fields == 4) begin
                        check_readout(count, red, label);
                    end else begin
                        $display("An expect line has %0d fields instead of 4.", fields);
                        file_errors++;
                    end
                end
            end
            if (in_frame) begin
                end_frame();
            end
            $fclose(fd);
        end
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================

    initial begin
        int stim_cycles;
        int stim_frames;
        arst_n         = 1'b0;
        red_in         = '0;
        green_in       = '0;
        blue_in        = '0;
        line_valid     = 1'b0;
        frame_valid    = 1'b0;
        read_address   = '0;
        check_valid    = 1'b0;
        check_name     = '0;
        check_expected = '0;
        file_errors    = 0;
        frame_number   = 0;
        measure_stim(stim_cycles, stim_frames);
        cycle_limit = RESET_CYCLES + stim_cycles + FRAME_MARGIN * stim_frames;
        repeat (RESET_CYCLES) @(posedge clock_in);
        arst_n <= 1'b1;
        play_stim();
        repeat (4) @(posedge clock_in);
        $display("Readout checks %0d, errors %0d, file errors %0d.",
                 check_count, error_count, file_errors);
        if (error_count == 0 && file_errors == 0 && check_count > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        wait (cycle_limit > 0);
        repeat (cycle_limit) @(posedge clock_in);
        $display("Watchdog expired after %0d cycles before the stimulus finished.", cycle_limit);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/image_stim.txt */
# frame and line open a frame or a line; run <count> <red> <green> <blue> <blank cycles after>
# expect <address> <value> <label> is read back once the frame has ended; all numbers decimal.
frame
line
run 1 127 128 0 0
run 3 128 124 1023 2
line
run 2 512 640 1000 0
run 1 999 3 400 1
line
run 4 300 300 300 0
expect 0 1 red_bin0_edge
expect 1 3 red_bin1_edge
expect 2 4 red_bin2_last
expect 7 1 red_bin7
expect 8 4 green_bin0
expect 9 1 green_bin1
expect 19 1 blue_bin3
expect 23 5 blue_bin7
expect 48 249 red_max
expect 49 160 green_max
expect 50 255 blue_max
expect 51 5 clip_count
expect 24 0 unmapped_24
frame
line
run 1100 64 900 40 2
line
run 7 640 500 1023 0
expect 0 1023 red_bin0_saturated
expect 1 0 red_bin1_cleared
expect 5 7 red_bin5
expect 8 0 green_bin0_cleared
expect 11 7 green_bin3
expect 15 1023 green_bin7_saturated
expect 16 1023 blue_bin0_saturated
expect 23 7 blue_bin7
expect 48 160 red_max
expect 49 225 green_max
expect 50 255 blue_max
expect 51 7 clip_count
expect 200 0 unmapped_200

/* tb/stats_checker.sv */
// Testbench monitor that compares readout words and checks the ready level around frame ends.
`timescale 1ns/1ps
`default_nettype none

module stats_checker #(
    parameter int READY_WINDOW = 4  // Cycles allowed from frame end to ready.
)(
    input  logic                  clock_in,
    input  logic                  arst_n,
    input  logic                  frame_valid,
    input  logic                  stats_ready,
    input  stats_pkg::stat_word_t read_data,
    input  logic                  check_valid,
    input  logic [8*32-1:0]       check_name,
    input  stats_pkg::stat_word_t check_expected,
    output int                    check_count,
    output int                    error_count
);

    logic previous_frame_valid;
    int   ready_wait;           // Nonzero while a ready level is awaited.

    initial begin
        check_count          = 0;
        error_count          = 0;
        previous_frame_valid = 1'b0;
        ready_wait           = 0;
    end

    // ======================================================================
    // Frame timing and readout compare
    // ======================================================================

    always @(posedge clock_in) begin
        previous_frame_valid <= frame_valid;
        if (!arst_n) begin
            ready_wait <= 0;
            if (stats_ready || read_data != '0) begin
                $display("Outputs not cleared in reset: stats_ready %0b, read_data %0d.",
                         stats_ready, read_data);
                error_count = error_count + 1;
            end
        end else begin
            if (frame_valid && previous_frame_valid && stats_ready) begin
                $display("stats_ready is high while a frame is in progress at %0t.", $time);
                error_count = error_count + 1;
            end
            if (previous_frame_valid && !frame_valid) begin
                ready_wait <= 1;                    // Frame end seen on the input.
            end else if (ready_wait != 0) begin
                if (stats_ready) begin
                    ready_wait <= 0;
                end else if (ready_wait >= READY_WINDOW) begin
                    $display("stats_ready never rose after frame end");
                    error_count = error_count + 1;
                    ready_wait <= 0;
                end else begin
                    ready_wait <= ready_wait + 1;
                end
            end
            if (check_valid) begin
                check_count = check_count + 1;
                if (read_data !== check_expected) begin
                    $display("MISMATCH %0s: expected %0d, actual %0d",
                             check_name, check_expected, read_data);
                    error_count = error_count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire
